/* files.f */
ahbPkg.sv
ahbDecoder.sv
ahbSlaveMux.sv
ahbInterconnect.sv
ahbSram.sv
ahbWaitRegs.sv
ahbDefaultSlave.sv
ahbSubsystem.sv
ahbInterconnect_properties.sv
tbAhbSubsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the AHB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tbAhbSubsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VtbAhbSubsystem)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* tbAhbSubsystem.sv */
module tbAhbSubsystem;

    localparam int NUM_ENTRIES    = 27;
    localparam int RESET_CYCLES   = 2;
    // Each transfer takes at most 3 cycles, plus reset and some slack
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * NUM_ENTRIES + 16;

    typedef struct packed {
        ahbPkg::htransE trans;
        logic           write;
        logic [31:0]    addr;
        logic [31:0]    wData;
        logic [31:0]    expRData;
        ahbPkg::hrespE  expResp;
    } entryT;

    logic           HCLK;
    logic           rstN;
    logic [31:0]    hAddr;
    ahbPkg::htransE hTrans;
    logic           hWrite;
    logic [31:0]    hWData;
    logic [31:0]    hRData;
    logic           hReady;
    ahbPkg::hrespE  hResp;

    entryT stim [NUM_ENTRIES];
    int    rowCount;
    int    checkCount;
    int    errorCount;
    int    cycleCount;

    ahbSubsystem u_ahbSubsystem (
        .HCLK   (HCLK),
        .rstN   (rstN),
        .hAddr  (hAddr),
        .hTrans (hTrans),
        .hWrite (hWrite),
        .hWData (hWData),
        .hRData (hRData),
        .hReady (hReady),
        .hResp  (hResp)
    );

    bind ahbInterconnect ahbInterconnectProperties u_ahbInterconnectProperties (
        .HCLK   (HCLK),
        .rstN   (rstN),
        .hSel   (hSel),
        .hReady (hReady),
        .hResp  (hResp)
    );

    initial begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge HCLK);
            cycleCount++;
        end
        $display("Timeout: the bus transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus table and expected results
    // ------------------------------------------------------------------------
    task automatic addEntry(input ahbPkg::htransE trans, input logic write,
                            input logic [31:0] addr, input logic [31:0] wData,
                            input logic [31:0] expRData, input ahbPkg::hrespE expResp);
        stim[rowCount] = '{trans, write, addr, wData, expRData, expResp};
        rowCount++;
    endtask

    task automatic loadTable();
        rowCount = 0;
        addEntry(ahbPkg::IDLE,   1'b0, 32'h0000_0000, 32'h0, 32'h0, ahbPkg::OKAY);
        // SRAM writes, an IDLE that must not write, then readback
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h0000_0000, 32'h1111_0000, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h0000_0004, 32'h2222_0004, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h0000_003C, 32'h3333_003C, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::IDLE,   1'b1, 32'h0000_0004, 32'hDEAD_BEEF, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h0000_0000, 32'h0, 32'h1111_0000, ahbPkg::OKAY);
        addEntry(ahbPkg::SEQ,    1'b0, 32'h0000_0004, 32'h0, 32'h2222_0004, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h0000_003C, 32'h0, 32'h3333_003C, ahbPkg::OKAY);
        // Register slave with register 3 read before it is written
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h4000_0000, 32'hA0A0_0000, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h4000_0004, 32'hA1A1_0004, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h4000_0008, 32'hA2A2_0008, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_000C, 32'h0, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_0000, 32'h0, 32'hA0A0_0000, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_0004, 32'h0, 32'hA1A1_0004, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_0008, 32'h0, 32'hA2A2_0008, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h4000_000C, 32'hA3A3_000C, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_000C, 32'h0, 32'hA3A3_000C, ahbPkg::OKAY);
        // Unmapped space must leave SRAM word 0 intact
        addEntry(ahbPkg::NONSEQ, 1'b1, 32'h8000_0000, 32'hBAD0_0000, 32'h0, ahbPkg::ERROR);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h8000_0010, 32'h0, 32'h0, ahbPkg::ERROR);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h0000_0000, 32'h0, 32'h1111_0000, ahbPkg::OKAY);
        // Alternating targets back to back
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_0000, 32'h0, 32'hA0A0_0000, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'hC000_0000, 32'h0, 32'h0, ahbPkg::ERROR);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h0000_003C, 32'h0, 32'h3333_003C, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h8000_0004, 32'h0, 32'h0, ahbPkg::ERROR);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h4000_0008, 32'h0, 32'hA2A2_0008, ahbPkg::OKAY);
        addEntry(ahbPkg::IDLE,   1'b0, 32'h4000_0000, 32'h0, 32'h0, ahbPkg::OKAY);
        addEntry(ahbPkg::NONSEQ, 1'b0, 32'h0000_0004, 32'h0, 32'h2222_0004, ahbPkg::OKAY);
    endtask

    function automatic logic isActive(input ahbPkg::htransE trans);
        return (trans == ahbPkg::NONSEQ) || (trans == ahbPkg::SEQ);
    endfunction

    // SRAM and idle transfers complete at once and the others wait one cycle
    function automatic int expectedWaits(input entryT e);
        if (!isActive(e.trans)) begin
            return 0;
        end
        if ((e.addr & ahbPkg::REGION_MASK) == ahbPkg::SRAM_BASE) begin
            return 0;
        end
        return 1;
    endfunction

    task automatic checkTransfer(input int idx, input logic [31:0] rData,
                                 input ahbPkg::hrespE resp, input int waits);
        entryT e;
        e = stim[idx];
        checkCount++;
        if (resp !== e.expResp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: entry %0d response %s, expected %s",
                     $time, idx, resp.name(), e.expResp.name());
        end
        if (waits != expectedWaits(e)) begin
            errorCount++;
            $display("CHECK FAILED at %0t: entry %0d took %0d wait cycles, expected %0d",
                     $time, idx, waits, expectedWaits(e));
        end
        if (!e.write && isActive(e.trans) && rData !== e.expRData) begin
            errorCount++;
            $display("CHECK FAILED at %0t: entry %0d read data %h, expected %h",
                     $time, idx, rData, e.expRData);
        end
    endtask

    // ------------------------------------------------------------------------
    // Master driver
    // ------------------------------------------------------------------------
    initial begin : master
        int            addrIdx;
        int            dataIdx;
        int            nextIdx;
        int            doneCount;
        int            waitCnt;
        logic          sReady;
        ahbPkg::hrespE sResp;
        logic [31:0]   sRData;

        rstN       = 1'b0;
        hAddr      = '0;
        hTrans     = ahbPkg::IDLE;
        hWrite     = 1'b0;
        hWData     = '0;
        checkCount = 0;
        errorCount = 0;
        loadTable();

        repeat (RESET_CYCLES) @(posedge HCLK);
        rstN <= 1'b1;

        addrIdx   = -1;
        dataIdx   = -1;
        nextIdx   = 0;
        doneCount = 0;
        waitCnt   = 0;
        while (doneCount < NUM_ENTRIES) begin
            // Sample mid-cycle and act on the edge that ends the cycle
            @(negedge HCLK);
            sReady = hReady;
            sResp  = hResp;
            sRData = hRData;
            @(posedge HCLK);
            if (sReady) begin
                if (dataIdx >= 0) begin
                    checkTransfer(dataIdx, sRData, sResp, waitCnt);
                    doneCount++;
                end
                dataIdx = addrIdx;
                if (dataIdx >= 0) begin
                    hWData <= stim[dataIdx].wData;
                end
                if (nextIdx < NUM_ENTRIES) begin
                    hAddr   <= stim[nextIdx].addr;
                    hTrans  <= stim[nextIdx].trans;
                    hWrite  <= stim[nextIdx].write;
                    addrIdx = nextIdx;
                    nextIdx++;
                end else begin
                    hTrans  <= ahbPkg::IDLE;
                    hWrite  <= 1'b0;
                    addrIdx = -1;
                end
                waitCnt = 0;
            end else begin
                waitCnt++;
                checkCount++;
                if (dataIdx < 0) begin
                    errorCount++;
                    $display("CHECK FAILED at %0t: hReady low with no transfer in its data phase",
                             $time);
                end else if (sResp !== stim[dataIdx].expResp) begin
                    errorCount++;
                    $display("CHECK FAILED at %0t: entry %0d wait cycle response %s, expected %s",
                             $time, dataIdx, sResp.name(), stim[dataIdx].expResp.name());
                end
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* ahbInterconnect_properties.sv */
module ahbInterconnectProperties (
    input logic                          HCLK,
    input logic                          rstN,
    input logic [ahbPkg::NUM_SLAVES-1:0] hSel,
    input logic                          hReady,
    input ahbPkg::hrespE                 hResp
);

    // ------------------------------------------------------------------------
    // Decoder and response checks
    // ------------------------------------------------------------------------
    selOneHot: assert property (
        @(posedge HCLK) disable iff (!rstN) $onehot(hSel)
    ) else $error("hSel is not one-hot: %b", hSel);

    // Two-cycle ERROR response
    errorTwoCycle: assert property (
        @(posedge HCLK) disable iff (!rstN)
        (hResp == ahbPkg::ERROR && !hReady) |=> (hResp == ahbPkg::ERROR && hReady)
    ) else $error("ERROR response not completed in its second cycle");

    readyAfterReset: assert property (
        @(posedge HCLK) $rose(rstN) |-> hReady
    ) else $error("hReady low in the first cycle after reset");

endmodule

/* ahbSubsystem.sv */
module ahbSubsystem (
    input  logic           HCLK,
    input  logic           rstN,
    input  logic [31:0]    hAddr,
    input  ahbPkg::htransE hTrans,
    input  logic           hWrite,
    input  logic [31:0]    hWData,
    output logic [31:0]    hRData,
    output logic           hReady,
    output ahbPkg::hrespE  hResp
);

    logic [ahbPkg::NUM_SLAVES-1:0]    hSel;
    logic [ahbPkg::NUM_SLAVES-1:0]    hReadyOutS;
    logic [ahbPkg::NUM_SLAVES-1:0]    hRespS;
    logic [ahbPkg::NUM_SLAVES*32-1:0] hRDataS;

    ahbInterconnect u_ahbInterconnect (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .hAddr      (hAddr),
        .hSel       (hSel),
        .hReadyOutS (hReadyOutS),
        .hRespS     (hRespS),
        .hRDataS    (hRDataS),
        .hReady     (hReady),
        .hResp      (hResp),
        .hRData     (hRData)
    );

    // ------------------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------------------
    ahbSram u_ahbSram (
        .HCLK      (HCLK),
        .rstN      (rstN),
        .hSel      (hSel[ahbPkg::SLAVE_SRAM]),
        .hAddr     (hAddr),
        .hTrans    (hTrans),
        .hWrite    (hWrite),
        .hWData    (hWData),
        .hReady    (hReady),
        .hReadyOut (hReadyOutS[ahbPkg::SLAVE_SRAM]),
        .hResp     (hRespS[ahbPkg::SLAVE_SRAM]),
        .hRData    (hRDataS[ahbPkg::SLAVE_SRAM*32 +: 32])
    );

    ahbWaitRegs u_ahbWaitRegs (
        .HCLK      (HCLK),
        .rstN      (rstN),
        .hSel      (hSel[ahbPkg::SLAVE_REGS]),
        .hAddr     (hAddr),
        .hTrans    (hTrans),
        .hWrite    (hWrite),
        .hWData    (hWData),
        .hReady    (hReady),
        .hReadyOut (hReadyOutS[ahbPkg::SLAVE_REGS]),
        .hResp     (hRespS[ahbPkg::SLAVE_REGS]),
        .hRData    (hRDataS[ahbPkg::SLAVE_REGS*32 +: 32])
    );

    ahbDefaultSlave u_ahbDefaultSlave (
        .HCLK      (HCLK),
        .rstN      (rstN),
        .hSel      (hSel[ahbPkg::SLAVE_DEFAULT]),
        .hTrans    (hTrans),
        .hReady    (hReady),
        .hReadyOut (hReadyOutS[ahbPkg::SLAVE_DEFAULT]),
        .hResp     (hRespS[ahbPkg::SLAVE_DEFAULT])
    );

    // No read data from unmapped space
    assign hRDataS[ahbPkg::SLAVE_DEFAULT*32 +: 32] = '0;

endmodule

/* ahbDefaultSlave.sv */
module ahbDefaultSlave (
    input  logic           HCLK,
    input  logic           rstN,
    input  logic           hSel,
    input  ahbPkg::htransE hTrans,
    input  logic           hReady,
    output logic           hReadyOut,
    output logic           hResp
);

    ahbPkg::errStateE state;
    logic             accept;

    assign accept = hSel && hReady &&
                    (hTrans == ahbPkg::NONSEQ || hTrans == ahbPkg::SEQ);

    // ERR2 may overlap the next address phase
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            state <= ahbPkg::NO_ERR;
        end else begin
            case (state)
                ahbPkg::ERR1: state <= ahbPkg::ERR2;
                default:      state <= accept ? ahbPkg::ERR1 : ahbPkg::NO_ERR;
            endcase
        end
    end

    assign hReadyOut = (state != ahbPkg::ERR1);
    assign hResp     = (state == ahbPkg::NO_ERR) ? ahbPkg::OKAY : ahbPkg::ERROR;

endmodule

/* ahbWaitRegs.sv */
module ahbWaitRegs (
    input  logic           HCLK,
    input  logic           rstN,
    input  logic           hSel,
    input  logic [31:0]    hAddr,
    input  ahbPkg::htransE hTrans,
    input  logic           hWrite,
    input  logic [31:0]    hWData,
    input  logic           hReady,
    output logic           hReadyOut,
    output logic           hResp,
    output logic [31:0]    hRData
);

    ahbPkg::waitStateE state;

    logic [31:0] regs [4];
    logic [31:0] rData;
    logic [1:0]  regIdx;
    logic        wrFlag;
    logic        accept;

    assign accept = (state == ahbPkg::IDLE_ST) && hSel && hReady &&
                    (hTrans == ahbPkg::NONSEQ || hTrans == ahbPkg::SEQ);

    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            state  <= ahbPkg::IDLE_ST;
            wrFlag <= 1'b0;
            regIdx <= '0;
            rData  <= '0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                ahbPkg::IDLE_ST: begin
                    if (accept) begin
                        state  <= ahbPkg::WAIT_ST;
                        wrFlag <= hWrite;
                        regIdx <= hAddr[3:2];
                    end
                end
                // Data settles on the way back to idle
                ahbPkg::WAIT_ST: begin
                    state <= ahbPkg::IDLE_ST;
                    if (wrFlag) begin
                        regs[regIdx] <= hWData;
                    end else begin
                        rData <= regs[regIdx];
                    end
                end
                default: state <= ahbPkg::IDLE_ST;
            endcase
        end
    end

    assign hReadyOut = (state != ahbPkg::WAIT_ST);
    assign hResp     = ahbPkg::OKAY;
    assign hRData    = rData;

endmodule

/* ahbSram.sv */
module ahbSram (
    input  logic           HCLK,
    input  logic           rstN,
    input  logic           hSel,
    input  logic [31:0]    hAddr,
    input  ahbPkg::htransE hTrans,
    input  logic           hWrite,
    input  logic [31:0]    hWData,
    input  logic           hReady,
    output logic           hReadyOut,
    output logic           hResp,
    output logic [31:0]    hRData
);

    logic [31:0] mem [ahbPkg::SRAM_WORDS];

    logic                                  accept;
    logic                                  wrPend;
    logic [$clog2(ahbPkg::SRAM_WORDS)-1:0] wordIdx;

    assign accept = hSel && hReady &&
                    (hTrans == ahbPkg::NONSEQ || hTrans == ahbPkg::SEQ);

    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            wrPend <= 1'b0;
        end else begin
            wrPend <= accept && hWrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            wordIdx <= hAddr[$clog2(ahbPkg::SRAM_WORDS)+1:2];
        end
    end

    // Write lands at the end of the data phase
    always_ff @(posedge HCLK) begin
        if (wrPend) begin
            mem[wordIdx] <= hWData;
        end
    end

    assign hRData    = mem[wordIdx];
    assign hReadyOut = 1'b1;
    assign hResp     = ahbPkg::OKAY;

endmodule

/* ahbInterconnect.sv */
module ahbInterconnect (
    input  logic                             HCLK,
    input  logic                             rstN,
    input  logic [31:0]                      hAddr,
    output logic [ahbPkg::NUM_SLAVES-1:0]    hSel,
    input  logic [ahbPkg::NUM_SLAVES-1:0]    hReadyOutS,
    input  logic [ahbPkg::NUM_SLAVES-1:0]    hRespS,
    input  logic [ahbPkg::NUM_SLAVES*32-1:0] hRDataS,
    output logic                             hReady,
    output ahbPkg::hrespE                    hResp,
    output logic [31:0]                      hRData
);

    // ------------------------------------------------------------------------
    // Decoder
    // ------------------------------------------------------------------------
    ahbDecoder u_ahbDecoder (
        .hAddr (hAddr),
        .hSel  (hSel)
    );

    // ------------------------------------------------------------------------
    // Slave multiplexer
    // ------------------------------------------------------------------------
    ahbSlaveMux u_ahbSlaveMux (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .hSel       (hSel),
        .hReadyOutS (hReadyOutS),
        .hRespS     (hRespS),
        .hRDataS    (hRDataS),
        .hReady     (hReady),
        .hResp      (hResp),
        .hRData     (hRData)
    );

endmodule

/* ahbSlaveMux.sv */
module ahbSlaveMux (
    input  logic                             HCLK,
    input  logic                             rstN,
    input  logic [ahbPkg::NUM_SLAVES-1:0]    hSel,
    input  logic [ahbPkg::NUM_SLAVES-1:0]    hReadyOutS,
    input  logic [ahbPkg::NUM_SLAVES-1:0]    hRespS,
    input  logic [ahbPkg::NUM_SLAVES*32-1:0] hRDataS,
    output logic                             hReady,
    output ahbPkg::hrespE                    hResp,
    output logic [31:0]                      hRData
);

    // Select of the transfer currently in its data phase
    logic [ahbPkg::NUM_SLAVES-1:0] dataSel;

    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            dataSel <= ahbPkg::NUM_SLAVES'(1) << ahbPkg::SLAVE_DEFAULT;
        end else if (hReady) begin
            dataSel <= hSel;
        end
    end

    // ------------------------------------------------------------------------
    // One-hot AND-OR return path
    // ------------------------------------------------------------------------
    assign hReady = |(dataSel & hReadyOutS);
    assign hResp  = ahbPkg::hrespE'(|(dataSel & hRespS));

    always_comb begin
        hRData = '0;
        for (int i = 0; i < ahbPkg::NUM_SLAVES; i++) begin
            if (dataSel[i]) begin
                hRData = hRData | hRDataS[i*32 +: 32];
            end
        end
    end

endmodule

/* ahbDecoder.sv */
module ahbDecoder (
    input  logic [31:0]                  hAddr,
    output logic [ahbPkg::NUM_SLAVES-1:0] hSel
);

    logic [31:0] region;

    assign region = hAddr & ahbPkg::REGION_MASK;

    // Unmapped space falls through to the default slave
    always_comb begin
        hSel = '0;
        if (region == ahbPkg::SRAM_BASE) begin
            hSel[ahbPkg::SLAVE_SRAM] = 1'b1;
        end else if (region == ahbPkg::REGS_BASE) begin
            hSel[ahbPkg::SLAVE_REGS] = 1'b1;
        end else begin
            hSel[ahbPkg::SLAVE_DEFAULT] = 1'b1;
        end
    end

endmodule

/* ahbPkg.sv */
package ahbPkg;

    // ------------------------------------------------------------------------
    // Slave ports
    // ------------------------------------------------------------------------
    localparam int NUM_SLAVES    = 3;
    localparam int SLAVE_SRAM    = 0;
    localparam int SLAVE_REGS    = 1;
    localparam int SLAVE_DEFAULT = 2;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam logic [31:0] SRAM_BASE   = 32'h0000_0000;
    localparam logic [31:0] REGS_BASE   = 32'h4000_0000;
    // 4 KB regions
    localparam logic [31:0] REGION_MASK = 32'hFFFF_F000;

    localparam int SRAM_WORDS = 16;

    // ------------------------------------------------------------------------
    // Bus encodings and slave states
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htransE;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hrespE;

    typedef enum logic {
        IDLE_ST,
        WAIT_ST
    } waitStateE;

    typedef enum logic [1:0] {
        NO_ERR,
        ERR1,
        ERR2
    } errStateE;

endpackage
